// ==== filelist.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/core.sv
testbench/tb_memory_model.sv
testbench/tb_core.sv

// ==== rtl/core.sv ====
`default_nettype none

module core (
    input  wire logic            clk,
    input  wire logic            reset,

    output logic                 inst_start,
    input  wire logic            inst_ready,
    output core_pkg::word_t      inst_addr,
    input  wire core_pkg::word_t inst,
    input  wire logic            inst_valid,

    output logic                 d_cmd_start,
    output logic                 d_cmd_write,
    input  wire logic            d_cmd_ready,
    output core_pkg::word_t      d_addr,
    output core_pkg::word_t      d_wdata,
    output core_pkg::word_t      d_wmask,
    input  wire core_pkg::word_t d_rdata,
    input  wire logic            d_rdata_valid
);

logic                  stall;
logic                  redirect;
core_pkg::word_t       redirect_pc;
core_pkg::reg_file_t   reg_file;
core_pkg::id_bundle_t  id_bundle;
core_pkg::ex_bundle_t  ex_bundle;
core_pkg::mem_bundle_t mem_bundle;
core_pkg::wb_bundle_t  wb_bundle;

// ********************
// fetch and decode
// ********************

fetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst_start  (inst_start),
    .inst_ready  (inst_ready),
    .inst_addr   (inst_addr),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .id_out      (id_bundle)
);

decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .id_in    (id_bundle),
    .reg_file (reg_file),
    .wb_in    (wb_bundle),
    .ex_out   (ex_bundle)
);

// ********************
// execute, memory, writeback
// ********************

execute_stage u_execute (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .ex_in       (ex_bundle),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_out     (mem_bundle)
);

memory_stage u_memory (
    .clk           (clk),
    .reset         (reset),
    .mem_in        (mem_bundle),
    .stall         (stall),
    .wb_out        (wb_bundle),
    .d_cmd_start   (d_cmd_start),
    .d_cmd_write   (d_cmd_write),
    .d_cmd_ready   (d_cmd_ready),
    .d_addr        (d_addr),
    .d_wdata       (d_wdata),
    .d_wmask       (d_wmask),
    .d_rdata       (d_rdata),
    .d_rdata_valid (d_rdata_valid)
);

writeback_stage u_writeback (
    .clk      (clk),
    .reset    (reset),
    .wb_in    (wb_bundle),
    .reg_file (reg_file)
);

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

typedef logic [`CORE_XLEN-1:0] word_t;
typedef logic [4:0]            reg_addr_t;
typedef word_t [31:0]          reg_file_t;

typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS2
} alu_op_e;

typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JAL} branch_e;

typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

typedef enum logic [1:0] {F_IDLE, F_WAIT, F_FULL} fetch_state_e;

typedef enum logic [1:0] {M_IDLE, M_WAIT_READY, M_WAIT_DATA} mem_state_e;

// fetch -> decode
typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
} id_bundle_t;

// decode -> execute
typedef struct packed {
    logic      valid;
    word_t     pc;
    alu_op_e   alu_op;
    word_t     op1;
    word_t     op2;
    word_t     rs2_data;
    word_t     imm_b;
    word_t     imm_j;
    branch_e   branch;
    logic      mem_read;
    logic      mem_write;
    logic      rf_wen;
    wb_sel_e   wb_sel;
    reg_addr_t wb_addr;
} ex_bundle_t;

// execute -> memory
typedef struct packed {
    logic      valid;
    word_t     alu_out;
    word_t     rs2_data;
    word_t     pc_plus4;
    logic      mem_read;
    logic      mem_write;
    logic      rf_wen;
    wb_sel_e   wb_sel;
    reg_addr_t wb_addr;
} mem_bundle_t;

// memory -> writeback
typedef struct packed {
    logic      valid;
    logic      rf_wen;
    reg_addr_t wb_addr;
    word_t     data;
} wb_bundle_t;

endpackage

`default_nettype wire

// ==== rtl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

// data and address width
`define CORE_XLEN 32

`endif

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall,
    input  wire logic                 redirect,
    input  wire core_pkg::id_bundle_t id_in,
    input  wire core_pkg::reg_file_t  reg_file,
    input  wire core_pkg::wb_bundle_t wb_in,
    output core_pkg::ex_bundle_t      ex_out
);

localparam logic [6:0] OP_LUI    = 7'b0110111;
localparam logic [6:0] OP_IMM    = 7'b0010011;
localparam logic [6:0] OP_REG    = 7'b0110011;
localparam logic [6:0] OP_LOAD   = 7'b0000011;
localparam logic [6:0] OP_STORE  = 7'b0100011;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_JAL    = 7'b1101111;

core_pkg::word_t      inst;
logic [6:0]           opcode;
logic [2:0]           funct3;
logic [6:0]           funct7;
core_pkg::reg_addr_t  rs1;
core_pkg::reg_addr_t  rs2;
core_pkg::reg_addr_t  rd;
core_pkg::word_t      imm_i;
core_pkg::word_t      imm_s;
core_pkg::word_t      imm_b;
core_pkg::word_t      imm_j;
core_pkg::word_t      imm_u;
logic                 rs1_hit;
logic                 rs2_hit;
core_pkg::word_t      rs1_data;
core_pkg::word_t      rs2_data;
core_pkg::ex_bundle_t dec;

assign inst   = id_in.inst;
assign opcode = inst[6:0];
assign funct3 = inst[14:12];
assign funct7 = inst[31:25];
assign rs1    = inst[19:15];
assign rs2    = inst[24:20];
assign rd     = inst[11:7];

assign imm_i = {{20{inst[31]}}, inst[31:20]};
assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
assign imm_u = {inst[31:12], 12'b0};

// write-first: a value landing this edge is seen now
assign rs1_hit  = wb_in.valid && wb_in.rf_wen && wb_in.wb_addr == rs1 && rs1 != '0;
assign rs2_hit  = wb_in.valid && wb_in.rf_wen && wb_in.wb_addr == rs2 && rs2 != '0;
assign rs1_data = rs1_hit ? wb_in.data : reg_file[rs1];
assign rs2_data = rs2_hit ? wb_in.data : reg_file[rs2];

always_comb begin
    dec          = '0;
    dec.valid    = id_in.valid;
    dec.pc       = id_in.pc;
    dec.alu_op   = core_pkg::ALU_ADD;
    dec.op1      = rs1_data;
    dec.op2      = imm_i;
    dec.rs2_data = rs2_data;
    dec.imm_b    = imm_b;
    dec.imm_j    = imm_j;
    dec.branch   = core_pkg::BR_NONE;
    dec.wb_sel   = core_pkg::WB_ALU;
    dec.wb_addr  = rd;
    case (opcode)
        OP_LUI: begin
            dec.alu_op = core_pkg::ALU_PASS2;
            dec.op1    = '0;
            dec.op2    = imm_u;
            dec.rf_wen = 1'b1;
        end
        OP_IMM: begin
            // addi only
            dec.rf_wen = 1'b1;
            dec.valid  = id_in.valid && funct3 == 3'b000;
        end
        OP_REG: begin
            dec.op2    = rs2_data;
            dec.rf_wen = 1'b1;
            case ({funct7, funct3})
                {7'h00, 3'b000}: dec.alu_op = core_pkg::ALU_ADD;
                {7'h20, 3'b000}: dec.alu_op = core_pkg::ALU_SUB;
                {7'h00, 3'b111}: dec.alu_op = core_pkg::ALU_AND;
                {7'h00, 3'b110}: dec.alu_op = core_pkg::ALU_OR;
                {7'h00, 3'b100}: dec.alu_op = core_pkg::ALU_XOR;
                {7'h00, 3'b010}: dec.alu_op = core_pkg::ALU_SLT;
                default:         dec.valid  = 1'b0;
            endcase
        end
        OP_LOAD: begin
            dec.mem_read = 1'b1;
            dec.rf_wen   = 1'b1;
            dec.wb_sel   = core_pkg::WB_MEM;
            dec.valid    = id_in.valid && funct3 == 3'b010;
        end
        OP_STORE: begin
            dec.op2       = imm_s;
            dec.mem_write = 1'b1;
            dec.valid     = id_in.valid && funct3 == 3'b010;
        end
        OP_BRANCH: begin
            dec.op2 = rs2_data;
            case (funct3)
                3'b000:  dec.branch = core_pkg::BR_EQ;
                3'b001:  dec.branch = core_pkg::BR_NE;
                default: dec.valid  = 1'b0;
            endcase
        end
        OP_JAL: begin
            dec.branch = core_pkg::BR_JAL;
            dec.rf_wen = 1'b1;
            dec.wb_sel = core_pkg::WB_PC4;
        end
        default: dec.valid = 1'b0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset || redirect) begin
        ex_out <= '0;
    end else if (!stall) begin
        ex_out <= dec;
    end
end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall,
    input  wire core_pkg::ex_bundle_t ex_in,
    output logic                      redirect,
    output core_pkg::word_t           redirect_pc,
    output core_pkg::mem_bundle_t     mem_out
);

core_pkg::word_t alu_out;
core_pkg::word_t target;
logic            equal;
logic            taken;

always_comb begin
    case (ex_in.alu_op)
        core_pkg::ALU_SUB:   alu_out = ex_in.op1 - ex_in.op2;
        core_pkg::ALU_AND:   alu_out = ex_in.op1 & ex_in.op2;
        core_pkg::ALU_OR:    alu_out = ex_in.op1 | ex_in.op2;
        core_pkg::ALU_XOR:   alu_out = ex_in.op1 ^ ex_in.op2;
        core_pkg::ALU_SLT:   alu_out = core_pkg::word_t'($signed(ex_in.op1) < $signed(ex_in.op2));
        core_pkg::ALU_PASS2: alu_out = ex_in.op2;
        default:             alu_out = ex_in.op1 + ex_in.op2;
    endcase
end

assign equal  = ex_in.op1 == ex_in.op2;
assign taken  = ex_in.valid && ((ex_in.branch == core_pkg::BR_EQ && equal) ||
                                (ex_in.branch == core_pkg::BR_NE && !equal) ||
                                ex_in.branch == core_pkg::BR_JAL);
assign target = ex_in.pc + ((ex_in.branch == core_pkg::BR_JAL) ? ex_in.imm_j : ex_in.imm_b);

always_ff @(posedge clk) begin
    if (reset) begin
        redirect <= 1'b0;
        mem_out  <= '0;
    end else begin
        // ex_in is wrong-path while redirect is high
        redirect <= taken && !redirect && !stall;
        if (!stall) begin
            mem_out.valid     <= ex_in.valid && !redirect;
            mem_out.alu_out   <= alu_out;
            mem_out.rs2_data  <= ex_in.rs2_data;
            mem_out.pc_plus4  <= ex_in.pc + core_pkg::word_t'(4);
            mem_out.mem_read  <= ex_in.mem_read;
            mem_out.mem_write <= ex_in.mem_write;
            mem_out.rf_wen    <= ex_in.rf_wen;
            mem_out.wb_sel    <= ex_in.wb_sel;
            mem_out.wb_addr   <= ex_in.wb_addr;
        end
    end
end

always_ff @(posedge clk) begin
    if (taken && !stall) begin
        redirect_pc <= target;
    end
end

a_redirect_src: assert property (@(posedge clk) disable iff (reset)
    $rose(redirect) |-> $past(ex_in.valid))
    else $error("redirect from an invalid bundle");

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`default_nettype none

`include "core_settings.svh"

module fetch_stage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 stall,
    input  wire logic                 redirect,
    input  wire core_pkg::word_t      redirect_pc,
    output logic                      inst_start,
    input  wire logic                 inst_ready,
    output core_pkg::word_t           inst_addr,
    input  wire core_pkg::word_t      inst,
    input  wire logic                 inst_valid,
    output core_pkg::id_bundle_t      id_out
);

localparam core_pkg::id_bundle_t BUBBLE = '{valid: 1'b0, pc: `CORE_RESET_PC, inst: `CORE_NOP};

core_pkg::fetch_state_e state;
core_pkg::word_t        pc;
core_pkg::id_bundle_t   buffer;
core_pkg::id_bundle_t   fetched;
logic                   running;
logic                   discard;
logic                   take;

assign inst_start = running && state == core_pkg::F_IDLE && inst_ready && !redirect;
assign inst_addr  = pc;

// response for the current path, not one left over from a redirect
assign take    = state == core_pkg::F_WAIT && inst_valid && !discard;
assign fetched = '{valid: 1'b1, pc: pc, inst: inst};

always_ff @(posedge clk) begin
    if (reset) begin
        state   <= core_pkg::F_IDLE;
        pc      <= `CORE_RESET_PC;
        running <= 1'b0;
        discard <= 1'b0;
    end else begin
        running <= 1'b1;
        if (redirect) begin
            pc <= redirect_pc;
            if (state == core_pkg::F_WAIT && !inst_valid) begin
                discard <= 1'b1;
            end else begin
                state   <= core_pkg::F_IDLE;
                discard <= 1'b0;
            end
        end else begin
            case (state)
                core_pkg::F_IDLE: begin
                    if (inst_start) begin
                        state <= core_pkg::F_WAIT;
                    end
                end
                core_pkg::F_WAIT: begin
                    if (inst_valid) begin
                        discard <= 1'b0;
                        state   <= (take && stall) ? core_pkg::F_FULL : core_pkg::F_IDLE;
                        if (take) begin
                            pc <= pc + core_pkg::word_t'(4);
                        end
                    end
                end
                core_pkg::F_FULL: begin
                    if (!stall) begin
                        state <= core_pkg::F_IDLE;
                    end
                end
                default: state <= core_pkg::F_IDLE;
            endcase
        end
    end
end

// one-entry buffer while decode is held
always_ff @(posedge clk) begin
    if (take && stall) begin
        buffer <= fetched;
    end
end

always_ff @(posedge clk) begin
    if (reset || redirect) begin
        id_out <= BUBBLE;
    end else if (!stall) begin
        if (state == core_pkg::F_FULL) begin
            id_out <= buffer;
        end else if (take) begin
            id_out <= fetched;
        end else begin
            id_out <= BUBBLE;
        end
    end
end

// only one request outstanding
a_one_request: assert property (@(posedge clk) disable iff (reset)
    inst_start |=> (!inst_start until inst_valid))
    else $error("inst_start with a request outstanding");

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
`default_nettype none

module memory_stage (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire core_pkg::mem_bundle_t mem_in,
    output logic                       stall,
    output core_pkg::wb_bundle_t       wb_out,
    output logic                       d_cmd_start,
    output logic                       d_cmd_write,
    input  wire logic                  d_cmd_ready,
    output core_pkg::word_t            d_addr,
    output core_pkg::word_t            d_wdata,
    output core_pkg::word_t            d_wmask,
    input  wire core_pkg::word_t       d_rdata,
    input  wire logic                  d_rdata_valid
);

core_pkg::mem_state_e state;
core_pkg::word_t      wb_data;
logic                 access;
logic                 issue;
logic                 done;

assign access = mem_in.valid && (mem_in.mem_read || mem_in.mem_write);
assign issue  = access && d_cmd_ready &&
                (state == core_pkg::M_IDLE || state == core_pkg::M_WAIT_READY);

// a write ends on acceptance, a read on its data
assign done  = (issue && mem_in.mem_write) || (state == core_pkg::M_WAIT_DATA && d_rdata_valid);
assign stall = access && !done;

assign d_cmd_start = issue;
assign d_cmd_write = mem_in.mem_write;
assign d_addr      = mem_in.alu_out;
assign d_wdata     = mem_in.rs2_data;
assign d_wmask     = '1;

always_ff @(posedge clk) begin
    if (reset) begin
        state <= core_pkg::M_IDLE;
    end else begin
        case (state)
            core_pkg::M_IDLE, core_pkg::M_WAIT_READY: begin
                if (issue) begin
                    state <= mem_in.mem_write ? core_pkg::M_IDLE : core_pkg::M_WAIT_DATA;
                end else if (access) begin
                    state <= core_pkg::M_WAIT_READY;
                end
            end
            core_pkg::M_WAIT_DATA: begin
                if (d_rdata_valid) begin
                    state <= core_pkg::M_IDLE;
                end
            end
            default: state <= core_pkg::M_IDLE;
        endcase
    end
end

always_comb begin
    case (mem_in.wb_sel)
        core_pkg::WB_MEM: wb_data = d_rdata;
        core_pkg::WB_PC4: wb_data = mem_in.pc_plus4;
        default:          wb_data = mem_in.alu_out;
    endcase
end

// bubbles to writeback while the access is pending
always_ff @(posedge clk) begin
    if (reset) begin
        wb_out <= '0;
    end else begin
        wb_out.valid   <= mem_in.valid && !stall;
        wb_out.rf_wen  <= mem_in.rf_wen;
        wb_out.wb_addr <= mem_in.wb_addr;
        wb_out.data    <= wb_data;
    end
end

a_rdata_window: assert property (@(posedge clk) disable iff (reset)
    d_rdata_valid |-> state == core_pkg::M_WAIT_DATA)
    else $error("d_rdata_valid outside M_WAIT_DATA");

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
`default_nettype none

module writeback_stage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire core_pkg::wb_bundle_t wb_in,
    output core_pkg::reg_file_t       reg_file
);

logic write_en;

// x0 is hardwired
assign write_en = wb_in.valid && wb_in.rf_wen && wb_in.wb_addr != '0;

always_ff @(posedge clk) begin
    if (reset) begin
        reg_file <= '0;
    end else if (write_en) begin
        reg_file[wb_in.wb_addr] <= wb_in.data;
    end
end

a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    wb_in.valid && wb_in.rf_wen && wb_in.wb_addr == '0 |=> reg_file[0] == '0)
    else $error("x0 written with %h", reg_file[0]);

endmodule

`default_nettype wire

// ==== testbench/tb_core.sv ====
`default_nettype none

`include "core_settings.svh"

module tb_core;

localparam core_pkg::word_t POISON_ADDR = 32'h0000_03f0;
localparam core_pkg::word_t DONE_ADDR   = 32'h0000_03fc;

logic            clk;
logic            reset;
logic            inst_start;
logic            inst_ready;
logic            inst_valid;
core_pkg::word_t inst_addr;
core_pkg::word_t inst;
logic            d_cmd_start;
logic            d_cmd_write;
logic            d_cmd_ready;
logic            d_rdata_valid;
core_pkg::word_t d_addr;
core_pkg::word_t d_wdata;
core_pkg::word_t d_wmask;
core_pkg::word_t d_rdata;
logic            store_valid;
core_pkg::word_t store_addr;
core_pkg::word_t store_data;

core_pkg::word_t prog[$];
core_pkg::word_t exp_addr[$];
core_pkg::word_t exp_data[$];
core_pkg::word_t xr[32];
core_pkg::word_t dshadow[core_pkg::word_t];
int              errors;
int              store_idx;
logic            done_seen;
logic            fetched_once;
logic            redirected;
core_pkg::word_t last_fetch;

core u_dut (
    .clk           (clk),
    .reset         (reset),
    .inst_start    (inst_start),
    .inst_ready    (inst_ready),
    .inst_addr     (inst_addr),
    .inst          (inst),
    .inst_valid    (inst_valid),
    .d_cmd_start   (d_cmd_start),
    .d_cmd_write   (d_cmd_write),
    .d_cmd_ready   (d_cmd_ready),
    .d_addr        (d_addr),
    .d_wdata       (d_wdata),
    .d_wmask       (d_wmask),
    .d_rdata       (d_rdata),
    .d_rdata_valid (d_rdata_valid)
);

tb_memory_model u_mem (
    .clk           (clk),
    .reset         (reset),
    .inst_start    (inst_start),
    .inst_addr     (inst_addr),
    .inst_ready    (inst_ready),
    .inst          (inst),
    .inst_valid    (inst_valid),
    .d_cmd_start   (d_cmd_start),
    .d_cmd_write   (d_cmd_write),
    .d_addr        (d_addr),
    .d_wdata       (d_wdata),
    .d_cmd_ready   (d_cmd_ready),
    .d_rdata       (d_rdata),
    .d_rdata_valid (d_rdata_valid),
    .store_valid   (store_valid),
    .store_addr    (store_addr),
    .store_data    (store_data)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// ********************
// encoders and ISA shadow
// ********************

function automatic core_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// each instruction gets two nops so no consumer sits close to its producer
task automatic put_inst(core_pkg::word_t w);
    prog.push_back(w);
    prog.push_back(`CORE_NOP);
    prog.push_back(`CORE_NOP);
endtask

task automatic set_reg(logic [4:0] rd, core_pkg::word_t v);
    if (rd != 0) begin
        xr[rd] = v;
    end
endtask

task automatic load_upper(logic [4:0] rd, logic [19:0] imm);
    put_inst({imm, rd, 7'b0110111});
    set_reg(rd, {imm, 12'h000});
endtask

task automatic add_imm(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    put_inst(enc_i(imm, rs1, 3'b000, rd, 7'b0010011));
    set_reg(rd, xr[rs1] + {{20{imm[11]}}, imm});
endtask

task automatic alu_reg(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                       logic [4:0] rs2);
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t r;
    a = xr[rs1];
    b = xr[rs2];
    case (f3)
        3'b000:  r = f7[5] ? a - b : a + b;
        3'b111:  r = a & b;
        3'b110:  r = a | b;
        3'b100:  r = a ^ b;
        default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
    put_inst({f7, rs2, rs1, f3, rd, 7'b0110011});
    set_reg(rd, r);
endtask

// stores and loads use x0 as base
task automatic store_word(logic [4:0] rs2, logic [11:0] off, logic expect_it);
    put_inst({off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011});
    if (expect_it) begin
        exp_addr.push_back({20'h0, off});
        exp_data.push_back(xr[rs2]);
        dshadow[{20'h0, off}] = xr[rs2];
    end
endtask

task automatic load_word(logic [4:0] rd, logic [11:0] off);
    put_inst(enc_i(off, 5'd0, 3'b010, rd, 7'b0000011));
    set_reg(rd, dshadow[{20'h0, off}]);
endtask

// branch +24 skips the poison store and its two nops
task automatic branch_over_store(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                 logic [11:0] off);
    logic        taken;
    logic [12:0] imm;
    imm   = 13'd24;
    taken = (f3 == 3'b000) ? (xr[rs1] == xr[rs2]) : (xr[rs1] != xr[rs2]);
    put_inst({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011});
    store_word(5'd5, taken ? POISON_ADDR[11:0] : off, !taken);
endtask

// poison store sits right after the jal, target is the first nop behind it
task automatic jal_over_store(logic [4:0] rd);
    logic [20:0] imm;
    imm = 21'd8;
    set_reg(rd, core_pkg::word_t'(prog.size() * 4 + 4));
    prog.push_back({imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111});
    store_word(5'd4, POISON_ADDR[11:0], 1'b0);
endtask

task automatic build_program();
    for (int r = 0; r < 32; r++) begin
        xr[r] = '0;
    end
    load_upper(5'd1, 20'h12345);
    add_imm(5'd2, 5'd0, -12'sd7);
    add_imm(5'd3, 5'd0, 12'd100);
    add_imm(5'd7, 5'd0, 12'h5a5);
    add_imm(5'd13, 5'd0, -12'sd3);
    alu_reg(7'h00, 3'b000, 5'd4, 5'd1, 5'd3);
    alu_reg(7'h20, 3'b000, 5'd5, 5'd3, 5'd2);
    alu_reg(7'h00, 3'b111, 5'd6, 5'd4, 5'd7);
    alu_reg(7'h00, 3'b110, 5'd8, 5'd1, 5'd7);
    alu_reg(7'h00, 3'b100, 5'd9, 5'd4, 5'd7);
    alu_reg(7'h00, 3'b010, 5'd10, 5'd2, 5'd3);
    alu_reg(7'h00, 3'b010, 5'd11, 5'd3, 5'd2);
    alu_reg(7'h00, 3'b010, 5'd12, 5'd2, 5'd13);
    for (int r = 1; r <= 13; r++) begin
        store_word(r[4:0], 12'h100 + 12'(r * 4), 1'b1);
    end
    // load/store round trip
    add_imm(5'd14, 5'd0, 12'h2c3);
    store_word(5'd14, 12'h180, 1'b1);
    load_word(5'd15, 12'h180);
    store_word(5'd15, 12'h184, 1'b1);
    branch_over_store(3'b000, 5'd3, 5'd3, 12'h188);
    branch_over_store(3'b001, 5'd3, 5'd2, 12'h18c);
    branch_over_store(3'b000, 5'd3, 5'd2, 12'h190);
    jal_over_store(5'd16);
    store_word(5'd16, 12'h194, 1'b1);
    store_word(5'd3, DONE_ADDR[11:0], 1'b1);
endtask

// ********************
// checks
// ********************

always @(negedge clk) begin
    if (reset) begin
        assert (!inst_start && !d_cmd_start) else begin
            errors++;
            $display("start strobe raised during reset");
        end
    end else begin
        if (inst_start) begin
            if (!fetched_once) begin
                assert (inst_addr == `CORE_RESET_PC) else begin
                    errors++;
                    $display("ERR inst_addr exp %h got %h", `CORE_RESET_PC, inst_addr);
                end
            end else if (!redirected) begin
                assert (inst_addr == last_fetch + 32'd4) else begin
                    errors++;
                    $display("ERR inst_addr exp %h got %h", last_fetch + 32'd4, inst_addr);
                end
            end
            fetched_once = 1'b1;
            redirected   = 1'b0;
            last_fetch   = inst_addr;
        end
        if (d_cmd_start) begin
            assert (d_wmask == 32'hffff_ffff) else begin
                errors++;
                $display("ERR d_wmask exp %h got %h", 32'hffff_ffff, d_wmask);
            end
        end
        if (u_dut.redirect) begin
            redirected = 1'b1;
        end
    end
end

always @(negedge clk) begin
    if (store_valid) begin
        assert (store_addr != POISON_ADDR) else begin
            errors++;
            $display("store reached the poison address");
        end
        assert (store_idx < exp_addr.size()) else begin
            errors++;
            $display("more stores than the program makes");
        end
        if (store_idx < exp_addr.size()) begin
            assert (store_addr == exp_addr[store_idx]) else begin
                errors++;
                $display("ERR store_addr exp %h got %h", exp_addr[store_idx], store_addr);
            end
            assert (store_data == exp_data[store_idx]) else begin
                errors++;
                $display("ERR store_data exp %h got %h", exp_data[store_idx], store_data);
            end
        end
        store_idx++;
        if (store_addr == DONE_ADDR) begin
            done_seen = 1'b1;
        end
    end
end

initial begin
    reset        = 1'b1;
    errors       = 0;
    store_idx    = 0;
    done_seen    = 1'b0;
    fetched_once = 1'b0;
    redirected   = 1'b0;
    last_fetch   = '0;
    build_program();
    @(posedge clk);
    for (int i = 0; i < prog.size(); i++) begin
        u_mem.imem[i] = prog[i];
    end
    fork
        begin
            #(prog.size() * 64 * 100);
            $display("timeout: program did not reach the done store");
            $display("errors: %0d, stores: %0d of %0d", errors + 1, store_idx,
                     exp_addr.size());
            $display("FAIL: see errors above");
            $finish;
        end
    join_none
    repeat (15) @(posedge clk);
    #5;
    reset = 1'b0;
    wait (done_seen);
    repeat (8) @(posedge clk);
    assert (store_idx == exp_addr.size()) else begin
        errors++;
        $display("store count differs from the expected table");
    end
    $display("errors: %0d, stores: %0d of %0d", errors, store_idx, exp_addr.size());
    if (errors == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== testbench/tb_memory_model.sv ====
`default_nettype none

module tb_memory_model (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            inst_start,
    input  wire core_pkg::word_t inst_addr,
    output logic                 inst_ready,
    output core_pkg::word_t      inst,
    output logic                 inst_valid,
    input  wire logic            d_cmd_start,
    input  wire logic            d_cmd_write,
    input  wire core_pkg::word_t d_addr,
    input  wire core_pkg::word_t d_wdata,
    output logic                 d_cmd_ready,
    output core_pkg::word_t      d_rdata,
    output logic                 d_rdata_valid,
    output logic                 store_valid,
    output core_pkg::word_t      store_addr,
    output core_pkg::word_t      store_data
);

core_pkg::word_t imem [0:255];
core_pkg::word_t dmem [0:255];
integer          seed;
int              i_hold;
int              i_wait;
int              d_hold;
int              d_wait;
logic            s_reset;
logic            s_istart;
logic            s_dstart;
logic            s_dwrite;
core_pkg::word_t s_iaddr;
core_pkg::word_t s_daddr;
core_pkg::word_t s_wdata;
core_pkg::word_t i_pend;
core_pkg::word_t d_pend;

initial begin
    seed          = 32'h5d38;
    inst_ready    = 1'b0;
    inst          = '0;
    inst_valid    = 1'b0;
    d_cmd_ready   = 1'b0;
    d_rdata       = '0;
    d_rdata_valid = 1'b0;
    store_valid   = 1'b0;
    store_addr    = '0;
    store_data    = '0;
    i_hold        = 0;
    i_wait        = 0;
    d_hold        = 0;
    d_wait        = 0;
    for (int a = 0; a < 256; a++) begin
        imem[a] = `CORE_NOP;
        dmem[a] = {8'ha5, a[7:0], ~a[7:0], 8'h5a};
    end
end

// sample mid-cycle, answer just after the next edge
always begin
    @(negedge clk);
    s_reset  = reset;
    s_istart = inst_start;
    s_iaddr  = inst_addr;
    s_dstart = d_cmd_start;
    s_dwrite = d_cmd_write;
    s_daddr  = d_addr;
    s_wdata  = d_wdata;
    @(posedge clk);
    #5;
    inst_valid    = 1'b0;
    d_rdata_valid = 1'b0;
    store_valid   = 1'b0;
    if (s_reset) begin
        // idle and ready while the core is held in reset
        inst_ready  = 1'b1;
        d_cmd_ready = 1'b1;
    end else begin
        // ********************
        // instruction port
        // ********************
        if (s_istart) begin
            i_pend = s_iaddr;
            i_wait = 1 + ($unsigned($random(seed)) % 3);
            i_hold = $unsigned($random(seed)) % 4;
        end
        if (i_wait > 0) begin
            i_wait--;
            if (i_wait == 0) begin
                inst_valid = 1'b1;
                inst       = imem[i_pend[9:2]];
            end
        end
        if (i_hold > 0) begin
            inst_ready = 1'b0;
            i_hold--;
        end else begin
            inst_ready = 1'b1;
        end
        // ********************
        // data port
        // ********************
        if (s_dstart) begin
            d_hold = $unsigned($random(seed)) % 4;
            if (s_dwrite) begin
                dmem[s_daddr[9:2]] = s_wdata;
                store_valid = 1'b1;
                store_addr  = s_daddr;
                store_data  = s_wdata;
            end else begin
                d_pend = s_daddr;
                d_wait = 1 + ($unsigned($random(seed)) % 3);
            end
        end
        if (d_wait > 0) begin
            d_wait--;
            if (d_wait == 0) begin
                d_rdata_valid = 1'b1;
                d_rdata       = dmem[d_pend[9:2]];
            end
        end
        if (d_hold > 0) begin
            d_cmd_ready = 1'b0;
            d_hold--;
        end else begin
            d_cmd_ready = 1'b1;
        end
    end
end

endmodule

`default_nettype wire
